//--- Makefile
# Verilator build and run for the instruction cache testbench

VERILATOR ?= verilator
TOP       ?= tb_icache
FILELIST  ?= icache_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  := Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP) -f $(FILELIST)

# Status comes from the pass line in the simulator output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- icache_top.f
rtl/icache_pkg.sv
rtl/icache_sdp_ram.sv
rtl/icache_lookup.sv
rtl/icache_refill.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
test/icache_asserts.sv
test/icache_checker.sv
test/tb_icache.sv

//--- rtl/icache_ctrl.sv
// Cache FSM for lookup, refill and single-set invalidation
// SPR writes are taken only in IDLE and a fetch wins over an SPR write
// Miss path is REFILL, WRITE, REREAD and then a second LOOKUP
`default_nettype none

module icache_ctrl (
   input  wire                               clk,
   input  wire                               rst,
   input  wire icache_pkg::fetch_req_t       fetch_i,
   output icache_pkg::fetch_rsp_t            fetch_o,
   input  wire icache_pkg::spr_req_t         spr_i,
   output logic                              spr_ack_o,
   output icache_pkg::set_idx_t              raddr_o,
   output logic [icache_pkg::ADDR_WIDTH-1:0] adr_o,
   input  wire icache_pkg::tag_entry_t       entry_i,
   input  wire                               hit_i,
   input  wire [icache_pkg::NUM_WAYS-1:0]    hit_way_i,
   input  wire icache_pkg::word_t            word_i,
   output logic                              tag_we_o,
   output icache_pkg::set_idx_t              tag_waddr_o,
   output icache_pkg::tag_entry_t            tag_din_o,
   output logic [icache_pkg::NUM_WAYS-1:0]   way_we_o,
   output icache_pkg::set_idx_t              way_waddr_o,
   output logic                              refill_start_o,
   output logic [icache_pkg::ADDR_WIDTH-1:0] refill_base_o,
   input  wire                               refill_done_i
);
   import icache_pkg::*;

   typedef enum logic [2:0] {IDLE, LOOKUP, REFILL, WRITE, REREAD} state_t;

   state_t                state_q;
   logic                  spr_ack_q;
   logic                  inv_q;
   set_idx_t              inv_set_q;
   logic [ADDR_WIDTH-1:0] adr_q;
   tag_entry_t            entry_q;
   set_idx_t              adr_set;
   set_idx_t              fetch_set;
   tag_t                  adr_tag;
   logic                  victim;
   logic                  accept_fetch;
   logic                  accept_spr;
   logic                  lookup_hit;

   assign fetch_set = fetch_i.adr[BLOCK_WIDTH +: SET_WIDTH];
   assign adr_set   = adr_q[BLOCK_WIDTH +: SET_WIDTH];
   assign adr_tag   = adr_q[ADDR_WIDTH-1 -: TAG_WIDTH];
   // Victim is the way the LRU bit named at the miss
   assign victim    = entry_q.lru;

   // Nothing new starts in the SPR ack cycle
   // This lets the invalidate land before the next tag read
   assign accept_fetch = (state_q == IDLE) && !spr_ack_q && fetch_i.stb;
   assign accept_spr   = (state_q == IDLE) && !spr_ack_q && !fetch_i.stb && spr_i.stb;
   assign lookup_hit   = (state_q == LOOKUP) && hit_i;

   // Control state
   always_ff @(posedge clk) begin
      if (rst) begin
         state_q   <= IDLE;
         spr_ack_q <= 1'b0;
         inv_q     <= 1'b0;
      end else begin
         // Every SPR write gets a one-cycle ack
         spr_ack_q <= accept_spr;
         inv_q     <= accept_spr && (spr_i.adr == SPR_ICBIR_ADDR);
         case (state_q)
            IDLE: begin
               if (accept_fetch) begin
                  state_q <= LOOKUP;
               end
            end
            LOOKUP:  state_q <= hit_i ? IDLE : REFILL;
            REFILL: begin
               if (refill_done_i) begin
                  state_q <= WRITE;
               end
            end
            WRITE:   state_q <= REREAD;
            REREAD:  state_q <= LOOKUP;
            default: state_q <= IDLE;
         endcase
      end
   end

   // Held request data
   always_ff @(posedge clk) begin
      if (accept_fetch) begin
         adr_q <= fetch_i.adr;
      end
      if (accept_spr) begin
         inv_set_q <= spr_i.dat[BLOCK_WIDTH +: SET_WIDTH];
      end
      // Entry at the miss, the untouched way is rewritten from it
      if (refill_start_o) begin
         entry_q <= entry_i;
      end
   end

   // RAM read index, held set while busy so REREAD sees the new line
   assign raddr_o = (state_q == IDLE) ? fetch_set : adr_set;
   assign adr_o   = adr_q;

   // Responses
   assign fetch_o   = '{ack: lookup_hit, dat: word_i};
   assign spr_ack_o = spr_ack_q;

   // Refill request on a miss, line aligned
   assign refill_start_o = (state_q == LOOKUP) && !hit_i;
   assign refill_base_o  = {adr_q[ADDR_WIDTH-1:BLOCK_WIDTH], {BLOCK_WIDTH{1'b0}}};

   // Tag and way RAM writes
   assign way_waddr_o = adr_set;

   always_comb begin
      tag_we_o    = 1'b0;
      tag_waddr_o = adr_set;
      tag_din_o   = entry_i;
      way_we_o    = '0;
      if (inv_q) begin
         // Clear both ways and the LRU bit of the named set
         tag_we_o    = 1'b1;
         tag_waddr_o = inv_set_q;
         tag_din_o   = '0;
      end else if (lookup_hit) begin
         // Point LRU away from the way just used
         tag_we_o      = 1'b1;
         tag_din_o.lru = hit_way_i[0];
      end else if (state_q == WRITE) begin
         // New line into the victim, other way kept as read at the miss
         tag_we_o              = 1'b1;
         tag_din_o             = entry_q;
         tag_din_o.way[victim] = '{valid: 1'b1, tag: adr_tag};
         tag_din_o.lru         = !victim;
         way_we_o[victim]      = 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- rtl/icache_lookup.sv
// Purely combinational hit check for the two ways
// Word output is only meaningful while hit_o is high
`default_nettype none

module icache_lookup (
   input  wire icache_pkg::tag_entry_t       entry_i,
   input  wire icache_pkg::line_t            line0_i,
   input  wire icache_pkg::line_t            line1_i,
   input  wire [icache_pkg::ADDR_WIDTH-1:0]  adr_i,
   output logic [icache_pkg::NUM_WAYS-1:0]   hit_way_o,
   output logic                              hit_o,
   output icache_pkg::word_t                 word_o
);
   import icache_pkg::*;

   tag_t                   adr_tag;
   logic [BLOCK_WIDTH-3:0] word_sel;
   line_t                  hit_line;

   // Tag sits above the set index
   assign adr_tag  = adr_i[ADDR_WIDTH-1 -: TAG_WIDTH];
   // Word within the line
   assign word_sel = adr_i[BLOCK_WIDTH-1:2];

   // Per-way compare, only valid entries can hit
   always_comb begin
      for (int w = 0; w < NUM_WAYS; w++) begin
         hit_way_o[w] = entry_i.way[w].valid && (entry_i.way[w].tag == adr_tag);
      end
   end

   assign hit_o = |hit_way_o;

   // Way 0 line passes when nothing hits
   assign hit_line = hit_way_o[1] ? line1_i : line0_i;

   // Addressed word of the hitting line
   assign word_o = hit_line[word_sel];

endmodule

`default_nettype wire

//--- rtl/icache_pkg.sv
// Fixed geometry of 2 ways, 16 sets, 16-byte lines and 32-bit byte addresses
// Tag and line RAMs have no reset, so software must invalidate all sets first
`default_nettype none

package icache_pkg;

   // Address split into tag, set index and byte offset
   localparam int ADDR_WIDTH     = 32;
   localparam int BLOCK_WIDTH    = 4;
   localparam int SET_WIDTH      = 4;
   localparam int TAG_WIDTH      = ADDR_WIDTH - SET_WIDTH - BLOCK_WIDTH;
   localparam int WORDS_PER_LINE = (1 << BLOCK_WIDTH) / 4;
   localparam int NUM_WAYS       = 2;

   // Block invalidate register
   // Written data bits 7:4 select the set
   localparam logic [15:0] SPR_ICBIR_ADDR = 16'h2002;

   typedef logic [31:0]          word_t;
   typedef logic [SET_WIDTH-1:0] set_idx_t;
   typedef logic [TAG_WIDTH-1:0] tag_t;

   // Word 0 sits in the low bits
   typedef word_t [WORDS_PER_LINE-1:0] line_t;

   typedef struct packed {
      logic valid;
      tag_t tag;
   } way_tag_t;

   // One tag RAM word per set
   // LRU bit names the way to replace next
   typedef struct packed {
      logic                    lru;
      way_tag_t [NUM_WAYS-1:0] way;
   } tag_entry_t;

   // CPU fetch port
   typedef struct packed {
      logic                  stb;
      logic [ADDR_WIDTH-1:0] adr;
   } fetch_req_t;

   typedef struct packed {
      logic  ack;
      word_t dat;
   } fetch_rsp_t;

   // SPR write port
   typedef struct packed {
      logic        stb;
      logic [15:0] adr;
      word_t       dat;
   } spr_req_t;

   // Wishbone classic master side, adr is word aligned
   typedef struct packed {
      logic                  cyc;
      logic                  stb;
      logic [ADDR_WIDTH-1:0] adr;
   } wb_m2s_t;

   typedef struct packed {
      logic  ack;
      word_t dat;
   } wb_s2m_t;

endpackage

`default_nettype wire

//--- rtl/icache_refill.sv
// Wishbone classic master that reads one line as separate word cycles
// cyc and stb drop for one cycle between words, no burst or bus error
// A start pulse is ignored while a refill is already running
`default_nettype none

module icache_refill (
   input  wire                              clk,
   input  wire                              rst,
   input  wire                              start_i,
   input  wire [icache_pkg::ADDR_WIDTH-1:0] base_i,
   output icache_pkg::wb_m2s_t              wb_o,
   input  wire icache_pkg::wb_s2m_t         wb_i,
   output logic                             done_o,
   output icache_pkg::line_t                line_o
);
   import icache_pkg::*;

   localparam int CNT_WIDTH = $clog2(WORDS_PER_LINE);

   logic                            busy_q;
   logic                            req_q;
   logic                            done_q;
   logic [CNT_WIDTH-1:0]            cnt_q;
   logic [ADDR_WIDTH-1:BLOCK_WIDTH] base_q;
   line_t                           line_q;
   logic                            start;
   logic                            word_ack;
   logic                            last_word;

   assign start     = start_i && !busy_q;
   assign word_ack  = req_q && wb_i.ack;
   assign last_word = (cnt_q == CNT_WIDTH'(WORDS_PER_LINE - 1));

   // Sequencer for the word cycles
   always_ff @(posedge clk) begin
      if (rst) begin
         busy_q <= 1'b0;
         req_q  <= 1'b0;
         done_q <= 1'b0;
         cnt_q  <= '0;
      end else begin
         done_q <= 1'b0;
         if (start) begin
            busy_q <= 1'b1;
            req_q  <= 1'b1;
            cnt_q  <= '0;
         end else if (word_ack) begin
            // Close this cycle, counter wraps after the last word
            req_q <= 1'b0;
            cnt_q <= cnt_q + 1'b1;
            if (last_word) begin
               busy_q <= 1'b0;
               done_q <= 1'b1;
            end
         end else if (busy_q && !req_q) begin
            // Idle gap over, open the next word cycle
            req_q <= 1'b1;
         end
      end
   end

   // Line base and assembly buffer
   always_ff @(posedge clk) begin
      if (start) begin
         base_q <= base_i[ADDR_WIDTH-1:BLOCK_WIDTH];
      end
      if (word_ack) begin
         line_q[cnt_q] <= wb_i.dat;
      end
   end

   // Word address from line base plus counter
   assign wb_o = '{cyc: req_q, stb: req_q, adr: {base_q, cnt_q, 2'b00}};

   // Buffer holds until the next start
   assign done_o = done_q;
   assign line_o = line_q;

endmodule

`default_nettype wire

//--- rtl/icache_sdp_ram.sv
// Simple dual-port RAM on one clock, one write port and one read port
// Read data arrives one cycle after the address with no write bypass
// A read of the address being written returns the old contents
`default_nettype none

module icache_sdp_ram #(
   parameter int  AW     = 4,
   parameter type data_t = logic [31:0]
) (
   input  wire          clk,
   input  wire          we_i,
   input  wire [AW-1:0] waddr_i,
   input  wire [AW-1:0] raddr_i,
   input  wire data_t   din_i,
   output data_t        dout_o
);

   // Storage array, contents undefined after power-up
   data_t mem [0:(1 << AW) - 1];

   always_ff @(posedge clk) begin
      // Write port
      if (we_i) begin
         mem[waddr_i] <= din_i;
      end
      // Registered read, sees the value before a same-edge write
      dout_o <= mem[raddr_i];
   end

endmodule

`default_nettype wire

//--- rtl/icache_top.sv
// Two-way instruction cache with LRU and Wishbone classic refill
// Fetch addresses must be word aligned
// All sets must be invalidated through ICBIR after reset before fetching
`default_nettype none

module icache_top (
   input  wire                        clk,
   input  wire                        rst,
   input  wire icache_pkg::fetch_req_t fetch_i,
   output icache_pkg::fetch_rsp_t     fetch_o,
   input  wire icache_pkg::spr_req_t  spr_i,
   output logic                       spr_ack_o,
   output icache_pkg::wb_m2s_t        wb_o,
   input  wire icache_pkg::wb_s2m_t   wb_i
);
   import icache_pkg::*;

   // Read side
   set_idx_t              raddr;
   logic [ADDR_WIDTH-1:0] adr;
   tag_entry_t            entry;
   line_t                 line0;
   line_t                 line1;
   logic [NUM_WAYS-1:0]   hit_way;
   logic                  hit;
   word_t                 word;

   // Write side
   logic                  tag_we;
   set_idx_t              tag_waddr;
   tag_entry_t            tag_din;
   logic [NUM_WAYS-1:0]   way_we;
   set_idx_t              way_waddr;

   // Refill handshake
   logic                  refill_start;
   logic [ADDR_WIDTH-1:0] refill_base;
   logic                  refill_done;
   line_t                 refill_line;

   // Valid, tag and LRU per set
   icache_sdp_ram #(.AW(SET_WIDTH), .data_t(tag_entry_t)) u_tag_ram (
      .clk     (clk),
      .we_i    (tag_we),
      .waddr_i (tag_waddr),
      .raddr_i (raddr),
      .din_i   (tag_din),
      .dout_o  (entry)
   );

   // Line storage, both ways written from the refill buffer
   icache_sdp_ram #(.AW(SET_WIDTH), .data_t(line_t)) u_way0_ram (
      .clk     (clk),
      .we_i    (way_we[0]),
      .waddr_i (way_waddr),
      .raddr_i (raddr),
      .din_i   (refill_line),
      .dout_o  (line0)
   );

   icache_sdp_ram #(.AW(SET_WIDTH), .data_t(line_t)) u_way1_ram (
      .clk     (clk),
      .we_i    (way_we[1]),
      .waddr_i (way_waddr),
      .raddr_i (raddr),
      .din_i   (refill_line),
      .dout_o  (line1)
   );

   icache_lookup u_lookup (
      .entry_i   (entry),
      .line0_i   (line0),
      .line1_i   (line1),
      .adr_i     (adr),
      .hit_way_o (hit_way),
      .hit_o     (hit),
      .word_o    (word)
   );

   icache_refill u_refill (
      .clk     (clk),
      .rst     (rst),
      .start_i (refill_start),
      .base_i  (refill_base),
      .wb_o    (wb_o),
      .wb_i    (wb_i),
      .done_o  (refill_done),
      .line_o  (refill_line)
   );

   icache_ctrl u_ctrl (
      .clk            (clk),
      .rst            (rst),
      .fetch_i        (fetch_i),
      .fetch_o        (fetch_o),
      .spr_i          (spr_i),
      .spr_ack_o      (spr_ack_o),
      .raddr_o        (raddr),
      .adr_o          (adr),
      .entry_i        (entry),
      .hit_i          (hit),
      .hit_way_i      (hit_way),
      .word_i         (word),
      .tag_we_o       (tag_we),
      .tag_waddr_o    (tag_waddr),
      .tag_din_o      (tag_din),
      .way_we_o       (way_we),
      .way_waddr_o    (way_waddr),
      .refill_start_o (refill_start),
      .refill_base_o  (refill_base),
      .refill_done_i  (refill_done)
   );

endmodule

`default_nettype wire

//--- test/icache_asserts.sv
// Handshake properties for the cache ports, bound into icache_top
// All properties are disabled while rst is high
`default_nettype none

module icache_asserts (
   input wire                         clk,
   input wire                         rst,
   input wire icache_pkg::fetch_req_t fetch_req_i,
   input wire icache_pkg::fetch_rsp_t fetch_rsp_i,
   input wire icache_pkg::wb_m2s_t    wb_m2s_i,
   input wire icache_pkg::wb_s2m_t    wb_s2m_i
);
   timeunit 1ns;
   timeprecision 100ps;

   // Failed property count, read by the testbench top
   int fail_cnt = 0;

   // Strobe only inside a Wishbone cycle
   wb_stb_in_cyc: assert property (@(posedge clk) disable iff (rst)
         wb_m2s_i.stb |-> wb_m2s_i.cyc)
      else begin
         fail_cnt++;
         $error("wb_o.stb high while wb_o.cyc is low");
      end

   // Address and strobe held until the slave acknowledges
   wb_adr_held: assert property (@(posedge clk) disable iff (rst)
         wb_m2s_i.stb && !wb_s2m_i.ack |=> wb_m2s_i.stb && $stable(wb_m2s_i.adr))
      else begin
         fail_cnt++;
         $error("wb_o.adr or wb_o.stb changed before wb_i.ack");
      end

   // Fetch ack lasts one cycle
   fetch_ack_single: assert property (@(posedge clk) disable iff (rst)
         fetch_rsp_i.ack |=> !fetch_rsp_i.ack)
      else begin
         fail_cnt++;
         $error("fetch_o.ack high in two consecutive cycles");
      end

   // No ack without a pending request
   fetch_ack_with_stb: assert property (@(posedge clk) disable iff (rst)
         fetch_rsp_i.ack |-> fetch_req_i.stb)
      else begin
         fail_cnt++;
         $error("fetch_o.ack high while fetch_i.stb is low");
      end

endmodule

`default_nettype wire

//--- test/icache_checker.sv
// Reference model of the two-way cache, fed only from the DUT ports
// Assumes fetch and SPR requests never overlap and each starts with the cache idle
// Memory word at byte address A is expected to read as A xor 32'h5a5a_0f0f
`default_nettype none

module icache_checker (
   input  wire                         clk,
   input  wire                         rst,
   input  wire icache_pkg::fetch_req_t fetch_req_i,
   input  wire icache_pkg::fetch_rsp_t fetch_rsp_i,
   input  wire icache_pkg::spr_req_t   spr_req_i,
   input  wire                         spr_ack_i,
   input  wire icache_pkg::wb_m2s_t    wb_m2s_i,
   input  wire icache_pkg::wb_s2m_t    wb_s2m_i,
   output int                          err_cnt_o,
   output int                          fetch_cnt_o,
   output int                          refill_cnt_o
);
   timeunit 1ns;
   timeprecision 100ps;
   import icache_pkg::*;

   localparam int    NUM_SETS = 1 << SET_WIDTH;
   localparam word_t MEM_XOR  = 32'h5a5a_0f0f;

   // Model state per set and way
   bit   valid [NUM_SETS][NUM_WAYS];
   tag_t tags  [NUM_SETS][NUM_WAYS];
   bit   lru   [NUM_SETS];

   // Outstanding fetch
   bit                    busy;
   bit                    cur_hit;
   int                    cur_way;
   int                    cycles;
   int                    wb_words;
   logic [ADDR_WIDTH-1:0] cur_adr;

   // Outstanding SPR write
   bit          spr_pending;
   logic [15:0] spr_adr;
   word_t       spr_dat;

   int err_cnt    = 0;
   int fetch_cnt  = 0;
   int refill_cnt = 0;

   assign err_cnt_o    = err_cnt;
   assign fetch_cnt_o  = fetch_cnt;
   assign refill_cnt_o = refill_cnt;

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      err_cnt++;
      $display("[FAIL] %s: got 0x%08h, expected 0x%08h (fetch 0x%08h, %0t)",
               name, got, exp, cur_adr, $time);
   endtask

   task automatic report_problem(input string msg);
      err_cnt++;
      $display("ERROR: %s at %0t", msg, $time);
   endtask

   // Hit or miss is decided from the model when the request is taken
   task automatic start_request();
      set_idx_t idx;
      tag_t     tag;
      cur_adr  = fetch_req_i.adr;
      idx      = cur_adr[BLOCK_WIDTH +: SET_WIDTH];
      tag      = cur_adr[ADDR_WIDTH-1 -: TAG_WIDTH];
      cur_hit  = 1'b0;
      cur_way  = 0;
      cycles   = 0;
      wb_words = 0;
      busy     = 1'b1;
      for (int w = 0; w < NUM_WAYS; w++) begin
         if (valid[idx][w] && tags[idx][w] == tag) begin
            cur_hit = 1'b1;
            cur_way = w;
         end
      end
   endtask

   // Each refill word must follow the line base in order
   task automatic check_wb_word();
      logic [ADDR_WIDTH-1:0] exp_adr;
      if (!busy || cur_hit) begin
         report_problem("Wishbone read while no miss is outstanding");
      end else begin
         exp_adr = {cur_adr[ADDR_WIDTH-1:BLOCK_WIDTH], {BLOCK_WIDTH{1'b0}}};
         exp_adr = exp_adr + 32'(wb_words * 4);
         if (wb_m2s_i.adr !== exp_adr) begin
            report_mismatch("wb_o.adr", wb_m2s_i.adr, exp_adr);
         end
      end
      wb_words++;
   endtask

   // Compare the answer, then apply the LRU and replacement rule
   task automatic finish_request();
      set_idx_t idx;
      tag_t     tag;
      int       victim;
      word_t    exp_dat;
      idx     = cur_adr[BLOCK_WIDTH +: SET_WIDTH];
      tag     = cur_adr[ADDR_WIDTH-1 -: TAG_WIDTH];
      exp_dat = cur_adr ^ MEM_XOR;
      if (fetch_rsp_i.dat !== exp_dat) begin
         report_mismatch("fetch_o.dat", fetch_rsp_i.dat, exp_dat);
      end
      if (cur_hit) begin
         // Ack belongs in the cycle after acceptance
         if (cycles != 1) begin
            report_mismatch("fetch_o.ack latency", cycles, 1);
         end
         lru[idx] = (cur_way == 0);
      end else begin
         if (wb_words != WORDS_PER_LINE) begin
            report_mismatch("wb_o read count", wb_words, WORDS_PER_LINE);
         end
         victim              = lru[idx];
         valid[idx][victim]  = 1'b1;
         tags[idx][victim]   = tag;
         lru[idx]            = (victim == 0);
         refill_cnt++;
      end
      fetch_cnt++;
      busy = 1'b0;
   endtask

   always @(posedge clk) begin
      if (rst) begin
         busy        = 1'b0;
         spr_pending = 1'b0;
         for (int s = 0; s < NUM_SETS; s++) begin
            lru[s] = 1'b0;
            for (int w = 0; w < NUM_WAYS; w++) begin
               valid[s][w] = 1'b0;
            end
         end
      end else begin
         if (wb_m2s_i.cyc && wb_m2s_i.stb && wb_s2m_i.ack) begin
            check_wb_word();
         end
         // Ack edge never starts a new request, the DUT is still in LOOKUP
         if (busy) begin
            cycles++;
            if (fetch_rsp_i.ack) begin
               finish_request();
            end
         end else begin
            if (fetch_rsp_i.ack) begin
               report_problem("fetch_o.ack without an outstanding fetch");
            end
            if (fetch_req_i.stb) begin
               start_request();
            end
         end
         // SPR write, ICBIR clears the whole entry of one set
         if (spr_ack_i) begin
            if (!spr_pending) begin
               report_problem("spr_ack_o without an SPR write");
            end else if (spr_adr == SPR_ICBIR_ADDR) begin
               lru[spr_dat[7:4]] = 1'b0;
               for (int w = 0; w < NUM_WAYS; w++) begin
                  valid[spr_dat[7:4]][w] = 1'b0;
               end
            end
            spr_pending = 1'b0;
         end else if (spr_req_i.stb && !spr_pending) begin
            spr_pending = 1'b1;
            spr_adr     = spr_req_i.adr;
            spr_dat     = spr_req_i.dat;
         end
      end
   end

endmodule

`default_nettype wire

//--- test/tb_icache.sv
// Testbench for the instruction cache with a Wishbone memory model
// Memory word at byte address A reads as A xor 32'h5a5a_0f0f with 0 to 3 wait states
// Every set is invalidated through ICBIR before the first fetch
`default_nettype none

module tb_icache;
   timeunit 1ns;
   timeprecision 100ps;
   import icache_pkg::*;

   localparam int          TIMEOUT_CYCLES = 200;
   localparam int          RANDOM_OPS     = 600;
   localparam word_t       MEM_XOR        = 32'h5a5a_0f0f;
   localparam logic [15:0] SPR_OTHER_ADDR = 16'h2003;
   localparam tag_t        POOL_TAGS [3]  = '{24'h000a31, 24'h01c7f2, 24'h3b0054};

   logic       clk = 1'b0;
   logic       rst;
   fetch_req_t fetch_req;
   fetch_rsp_t fetch_rsp;
   spr_req_t   spr_req;
   logic       spr_ack;
   wb_m2s_t    wb_m2s;
   wb_s2m_t    wb_s2m;

   int chk_errors;
   int chk_fetches;
   int chk_refills;
   int tb_errors = 0;
   int timeouts  = 0;
   int wb_reads  = 0;
   bit timed_out = 1'b0;

   // Memory model state for the current word cycle
   int wait_left = 0;
   bit in_cycle  = 1'b0;

   always #10 clk = ~clk;

   icache_top u_icache_top (
      .clk       (clk),
      .rst       (rst),
      .fetch_i   (fetch_req),
      .fetch_o   (fetch_rsp),
      .spr_i     (spr_req),
      .spr_ack_o (spr_ack),
      .wb_o      (wb_m2s),
      .wb_i      (wb_s2m)
   );

   icache_checker u_checker (
      .clk          (clk),
      .rst          (rst),
      .fetch_req_i  (fetch_req),
      .fetch_rsp_i  (fetch_rsp),
      .spr_req_i    (spr_req),
      .spr_ack_i    (spr_ack),
      .wb_m2s_i     (wb_m2s),
      .wb_s2m_i     (wb_s2m),
      .err_cnt_o    (chk_errors),
      .fetch_cnt_o  (chk_fetches),
      .refill_cnt_o (chk_refills)
   );

   bind icache_top icache_asserts u_asserts (
      .clk         (clk),
      .rst         (rst),
      .fetch_req_i (fetch_i),
      .fetch_rsp_i (fetch_o),
      .wb_m2s_i    (wb_o),
      .wb_s2m_i    (wb_i)
   );

   // Wishbone slave answering on the falling edge
   always @(negedge clk) begin
      if (rst) begin
         wb_s2m   = '0;
         in_cycle = 1'b0;
      end else begin
         wb_s2m.ack = 1'b0;
         if (wb_m2s.cyc && wb_m2s.stb) begin
            // Wait states drawn once per word cycle
            if (!in_cycle) begin
               in_cycle  = 1'b1;
               wait_left = $urandom % 4;
            end
            if (wait_left == 0) begin
               wb_s2m.ack = 1'b1;
               wb_s2m.dat = wb_m2s.adr ^ MEM_XOR;
               wb_reads++;
            end else begin
               wait_left--;
            end
         end else begin
            in_cycle = 1'b0;
         end
      end
   end

   function automatic logic [31:0] make_adr(input tag_t tag, input int idx, input int word);
      return {tag, idx[3:0], word[1:0], 2'b00};
   endfunction

   // Three tags over sets 0 to 3 keep the sets in conflict
   function automatic logic [31:0] pool_adr();
      int t;
      int s;
      int w;
      t = $urandom % 3;
      s = $urandom % 4;
      w = $urandom % 4;
      return make_adr(POOL_TAGS[t], s, w);
   endfunction

   // One fetch with an optional check of the line refills it caused
   task automatic fetch_word(input logic [31:0] adr, input int exp_refills);
      int cnt;
      int reads_before;
      if (!timed_out) begin
         reads_before  = wb_reads;
         fetch_req.stb = 1'b1;
         fetch_req.adr = adr;
         cnt           = 0;
         @(negedge clk);
         while (!fetch_rsp.ack && cnt < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cnt++;
         end
         if (!fetch_rsp.ack) begin
            $display("ERROR: no fetch_o.ack within %0d cycles for address 0x%08h",
                     TIMEOUT_CYCLES, adr);
            timeouts++;
            timed_out = 1'b1;
         end else begin
            // Request stays up through the acknowledging edge
            @(negedge clk);
            fetch_req.stb = 1'b0;
            if (exp_refills >= 0 && wb_reads - reads_before != 4 * exp_refills) begin
               $display("[FAIL] wb_o reads for fetch 0x%08h: got 0x%0h, expected 0x%0h",
                        adr, wb_reads - reads_before, 4 * exp_refills);
               tb_errors++;
            end
         end
      end
   endtask

   task automatic write_spr(input logic [15:0] adr, input word_t dat);
      int cnt;
      if (!timed_out) begin
         spr_req = '{stb: 1'b1, adr: adr, dat: dat};
         cnt     = 0;
         @(negedge clk);
         while (!spr_ack && cnt < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cnt++;
         end
         if (!spr_ack) begin
            $display("ERROR: no spr_ack_o within %0d cycles for SPR 0x%04h",
                     TIMEOUT_CYCLES, adr);
            timeouts++;
            timed_out = 1'b1;
         end else begin
            @(negedge clk);
            spr_req.stb = 1'b0;
         end
      end
   endtask

   task automatic invalidate_all();
      for (int s = 0; s < 16; s++) begin
         write_spr(SPR_ICBIR_ADDR, {24'h0, 4'(s), 4'h0});
      end
   endtask

   initial begin
      logic [31:0] adr_a;
      logic [31:0] adr_b;
      logic [31:0] adr_c;
      int          assert_fails;
      void'($urandom(32'hda8d_9e58));
      rst       = 1'b1;
      fetch_req = '0;
      spr_req   = '0;
      wb_s2m    = '0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      invalidate_all();

      // One line refilled and then hit three times
      fetch_word(make_adr(POOL_TAGS[0], 2, 0), 1);
      for (int w = 1; w < 4; w++) begin
         fetch_word(make_adr(POOL_TAGS[0], 2, w), 0);
      end

      // LRU in set 5 where C evicts B
      adr_a = make_adr(POOL_TAGS[0], 5, 1);
      adr_b = make_adr(POOL_TAGS[1], 5, 2);
      adr_c = make_adr(POOL_TAGS[2], 5, 3);
      fetch_word(adr_a, 1);
      fetch_word(adr_b, 1);
      fetch_word(adr_a, 0);
      fetch_word(adr_c, 1);
      fetch_word(adr_a, 0);
      fetch_word(adr_b, 1);

      // ICBIR empties set 5 and another SPR address leaves it alone
      write_spr(SPR_ICBIR_ADDR, 32'h0000_0050);
      fetch_word(adr_a, 1);
      write_spr(SPR_OTHER_ADDR, 32'h0000_0050);
      fetch_word(adr_a, 0);

      // Random mix checked by the model
      for (int i = 0; i < RANDOM_OPS; i++) begin
         if ($urandom % 8 == 0) begin
            if ($urandom % 4 == 0) begin
               write_spr(SPR_OTHER_ADDR, $urandom);
            end else begin
               write_spr(SPR_ICBIR_ADDR, {24'h0, 4'($urandom % 4), 4'h0});
            end
         end else begin
            fetch_word(pool_adr(), -1);
         end
      end

      repeat (2) @(negedge clk);
      if (wb_reads != 4 * chk_refills) begin
         $display("[FAIL] wb_o reads: got 0x%0h, expected 0x%0h", wb_reads, 4 * chk_refills);
         tb_errors++;
      end
      assert_fails = u_icache_top.u_asserts.fail_cnt;
      $write("Summary: %0d fetches, %0d refills, %0d checker errors, ",
             chk_fetches, chk_refills, chk_errors);
      $display("%0d assertion failures, %0d testbench errors, %0d timeouts",
               assert_fails, tb_errors, timeouts);
      if (chk_errors == 0 && assert_fails == 0 && tb_errors == 0 && timeouts == 0
          && chk_fetches > 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
